// File: common/tiny32_pkg.sv
`default_nettype none

package tiny32_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;

    typedef enum logic [6:0] {
        op_load   = 7'h03,
        op_store  = 7'h23,
        op_imm    = 7'h13,
        op_reg    = 7'h33,
        op_branch = 7'h63,
        op_lui    = 7'h37,
        op_auipc  = 7'h17,
        op_jal    = 7'h6f,
        op_jalr   = 7'h67,
        op_sys    = 7'h0b   // custom hlt, in and out
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_srl, alu_sra,
        alu_xor, alu_or, alu_and, alu_slt, alu_sltu
    } alu_op_e;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } mem_size_e;

    //////////////////////////////////////////////////
    // instruction formats

    typedef struct packed {
        logic [6:0] func7;
        reg_idx_t rs2;
        reg_idx_t rs1;
        logic [2:0] func3;
        reg_idx_t rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t rs1;
        logic [2:0] func3;
        reg_idx_t rd;
        logic [6:0] opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t rs2;
        reg_idx_t rs1;
        logic [2:0] func3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic imm12;
        logic [5:0] imm10_5;
        reg_idx_t rs2;
        reg_idx_t rs1;
        logic [2:0] func3;
        logic [3:0] imm4_1;
        logic imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t rd;
        logic [6:0] opcode;
    } u_fmt_t;

    typedef struct packed {
        logic imm20;
        logic [9:0] imm10_1;
        logic imm11;
        logic [7:0] imm19_12;
        reg_idx_t rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    //////////////////////////////////////////////////
    // decoded control and memory request

    typedef struct packed {
        opcode_e opcode;
        alu_op_e alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        logic op_a_pc;
        logic op_a_zero;
        logic op_b_imm;
        logic we;
        mem_size_e size;
        logic load_unsigned;
        logic [2:0] cond;       // func3 of a branch
        logic is_in;
        logic is_out;
        logic is_hlt;
        logic illegal;
        word_t imm;
    } dec_t;

    typedef struct packed {
        logic valid;
        logic write;
        mem_size_e size;
        logic uns;
        word_t address;
        word_t wdata;           // rs2 as is, memory aligns it
    } mem_req_t;

    localparam word_t reset_pc = 32'h4000_0000;
    localparam logic [1:0] region_rom = 2'd1;
    localparam logic [1:0] region_ram = 2'd2;

endpackage

`default_nettype wire

// File: design/tiny32_decoder.sv
`default_nettype none

module tiny32_decoder (
    input wire tiny32_pkg::instr_u instr,
    output tiny32_pkg::dec_t dec
);
    import tiny32_pkg::*;

    logic [2:0] func3;
    logic [6:0] func7;

    assign func3 = instr.r_fmt.func3;
    assign func7 = instr.r_fmt.func7;

    always_comb begin
        dec = '0;
        dec.opcode = opcode_e'(instr.r_fmt.opcode);
        dec.rs1 = instr.r_fmt.rs1;
        dec.rs2 = instr.r_fmt.rs2;
        dec.rd = instr.r_fmt.rd;
        dec.cond = func3;
        dec.size = mem_size_e'(func3[1:0]);
        dec.load_unsigned = func3[2];
        dec.alu_op = alu_add;

        case (instr.r_fmt.opcode)
            op_load: begin
                dec.we = 1'b1;
                dec.imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
                dec.illegal = func3[1:0] == 2'b11 || func3 == 3'b110;
            end
            op_store: begin
                dec.imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi,
                           instr.s_fmt.imm_lo};
                dec.illegal = func3[2] || func3[1:0] == 2'b11;
            end
            op_imm, op_reg: begin
                dec.we = 1'b1;
                dec.op_b_imm = instr.r_fmt.opcode == op_imm;
                dec.imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
                case (func3)
                    3'd0: dec.alu_op = (!dec.op_b_imm && func7[5]) ? alu_sub : alu_add;
                    3'd1: dec.alu_op = alu_sll;
                    3'd2: dec.alu_op = alu_slt;
                    3'd3: dec.alu_op = alu_sltu;
                    3'd4: dec.alu_op = alu_xor;
                    3'd5: dec.alu_op = func7[5] ? alu_sra : alu_srl;
                    3'd6: dec.alu_op = alu_or;
                    default: dec.alu_op = alu_and;
                endcase
                // multiply and divide use func7 = 1 and are not built
                dec.illegal = !dec.op_b_imm && func7 != 7'h00 && func7 != 7'h20;
            end
            op_branch: begin
                dec.alu_op = alu_sub;   // flags come from rs1 - rs2
                dec.imm = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                           instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
                dec.illegal = func3[2:1] == 2'b01;
            end
            op_lui, op_auipc: begin
                dec.we = 1'b1;
                dec.op_a_zero = instr.r_fmt.opcode == op_lui;
                dec.op_a_pc = instr.r_fmt.opcode == op_auipc;
                dec.op_b_imm = 1'b1;
                dec.imm = {instr.u_fmt.imm, 12'h000};
            end
            op_jal: begin
                dec.we = 1'b1;
                dec.imm = {{11{instr.j_fmt.imm20}}, instr.j_fmt.imm20, instr.j_fmt.imm19_12,
                           instr.j_fmt.imm11, instr.j_fmt.imm10_1, 1'b0};
            end
            op_jalr: begin
                dec.we = 1'b1;
                dec.imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            end
            op_sys: begin
                dec.is_hlt = func3 == 3'd2;
                dec.is_in = func3 == 3'd3;
                dec.is_out = func3 == 3'd4;
                dec.we = dec.is_in;
                dec.illegal = !(dec.is_hlt || dec.is_in || dec.is_out);
            end
            default: dec.illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: design/tiny32_alu.sv
`default_nettype none

module tiny32_alu (
    input wire logic clk,
    input wire tiny32_pkg::dec_t dec,
    input wire tiny32_pkg::word_t pc,
    input wire tiny32_pkg::word_t rs1_data,
    input wire tiny32_pkg::word_t rs2_data,
    input wire logic exec_en,
    output tiny32_pkg::word_t result,
    output logic taken
);
    import tiny32_pkg::*;

    word_t op_a, op_b;
    logic [32:0] diff;
    logic zero, carry, lt_signed, cond_met;

    assign op_a = dec.op_a_zero ? '0 : (dec.op_a_pc ? pc : rs1_data);
    assign op_b = dec.op_b_imm ? dec.imm : rs2_data;

    assign diff = {1'b0, op_a} - {1'b0, op_b};
    assign zero = diff[31:0] == '0;
    assign carry = diff[32];   // borrow, a below b unsigned
    assign lt_signed = (op_a[31] != op_b[31]) ? op_a[31] : diff[31];

    always_comb begin
        case (dec.cond)
            3'd0: cond_met = zero;
            3'd1: cond_met = !zero;
            3'd4: cond_met = lt_signed;
            3'd5: cond_met = !lt_signed;
            3'd6: cond_met = carry;
            3'd7: cond_met = !carry;
            default: cond_met = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (exec_en) begin
            taken <= cond_met && dec.opcode == op_branch;
            case (dec.alu_op)
                alu_sub: result <= diff[31:0];
                alu_sll: result <= op_a << op_b[4:0];
                alu_srl: result <= op_a >> op_b[4:0];
                alu_sra: result <= $signed(op_a) >>> op_b[4:0];
                alu_xor: result <= op_a ^ op_b;
                alu_or: result <= op_a | op_b;
                alu_and: result <= op_a & op_b;
                alu_slt: result <= {31'b0, lt_signed};
                alu_sltu: result <= {31'b0, carry};
                default: result <= op_a + op_b;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/tiny32_regfile.sv
`default_nettype none

module tiny32_regfile (
    input wire logic clk,
    input wire logic we,
    input wire tiny32_pkg::reg_idx_t waddr,
    input wire tiny32_pkg::word_t wdata,
    input wire tiny32_pkg::reg_idx_t raddr1,
    input wire tiny32_pkg::reg_idx_t raddr2,
    output tiny32_pkg::word_t rdata1,
    output tiny32_pkg::word_t rdata2
);
    import tiny32_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && waddr != '0)
            regs[waddr] <= wdata;
    end

    // x0 is never written and always reads zero
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: design/tiny32_pc.sv
`default_nettype none

module tiny32_pc (
    input wire logic clk,
    input wire logic nreset,
    input wire tiny32_pkg::dec_t dec,
    input wire tiny32_pkg::word_t rs1_data,
    input wire logic taken,
    input wire logic load,
    output tiny32_pkg::word_t pc,
    output tiny32_pkg::word_t pc_plus4
);
    import tiny32_pkg::*;

    word_t target;

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        case (dec.opcode)
            op_branch: target = taken ? pc + dec.imm : pc_plus4;
            op_jal: target = pc + dec.imm;
            op_jalr: target = (rs1_data + dec.imm) & ~32'd1;
            default: target = pc_plus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nreset)
            pc <= reset_pc;
        else if (load)
            pc <= target;   // once per instruction, in writeback
    end

endmodule

`default_nettype wire

// File: memory/tiny32_memory.sv
`default_nettype none

module tiny32_memory #(
    parameter int ram_bits = 10,
    parameter int rom_bits = 10
) (
    input wire logic clk,
    input wire logic fetch_en,
    input wire tiny32_pkg::word_t fetch_addr,
    input wire tiny32_pkg::mem_req_t req,
    output tiny32_pkg::word_t fetch_data,
    output tiny32_pkg::word_t load_data
);
    import tiny32_pkg::*;

    word_t rom [2**rom_bits];
    logic [3:0][7:0] ram [2**ram_bits];   // four byte lanes per word

    word_t rom_q, ram_q, rd_word, shifted;
    word_t rd_addr;
    logic [3:0] lane_we;
    logic [3:0][7:0] wr_lanes;
    logic wr_ram, sel_ram, ld_uns;
    logic [1:0] ld_off;
    mem_size_e ld_size;

    initial $readmemh("program.hex", rom);

    assign rd_addr = fetch_en ? fetch_addr : req.address;
    assign wr_ram = req.valid && req.write && req.address[31:30] == region_ram;

    //////////////////////////////////////////////////
    // store alignment

    always_comb begin
        case (req.size)
            size_byte: begin
                lane_we = 4'b0001 << req.address[1:0];
                wr_lanes = {4{req.wdata[7:0]}};
            end
            size_half: begin
                lane_we = req.address[1] ? 4'b1100 : 4'b0011;
                wr_lanes = {2{req.wdata[15:0]}};
            end
            default: begin
                lane_we = 4'b1111;
                wr_lanes = req.wdata;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (fetch_en || req.valid)
            rom_q <= rom[rd_addr[rom_bits+1:2]];
        if (req.valid) begin
            ram_q <= ram[req.address[ram_bits+1:2]];
            sel_ram <= req.address[31:30] == region_ram;
            ld_off <= req.address[1:0];
            ld_size <= req.size;
            ld_uns <= req.uns;
        end
        for (int i = 0; i < 4; i++) begin
            if (wr_ram && lane_we[i])
                ram[req.address[ram_bits+1:2]][i] <= wr_lanes[i];
        end
    end

    //////////////////////////////////////////////////
    // load extraction

    assign fetch_data = rom_q;
    assign rd_word = sel_ram ? ram_q : rom_q;
    assign shifted = rd_word >> {ld_off, 3'b000};

    always_comb begin
        case (ld_size)
            size_byte: load_data = ld_uns ? {24'b0, shifted[7:0]}
                                          : {{24{shifted[7]}}, shifted[7:0]};
            size_half: load_data = ld_uns ? {16'b0, shifted[15:0]}
                                          : {{16{shifted[15]}}, shifted[15:0]};
            default: load_data = rd_word;
        endcase
    end

endmodule

`default_nettype wire

// File: control/tiny32_control.sv
`default_nettype none

module tiny32_control (
    input wire logic clk,
    input wire logic nreset,
    input wire tiny32_pkg::dec_t dec,
    input wire tiny32_pkg::word_t fetch_data,
    input wire tiny32_pkg::word_t load_data,
    input wire tiny32_pkg::word_t alu_result,
    input wire tiny32_pkg::word_t pc,
    input wire tiny32_pkg::word_t pc_plus4,
    input wire tiny32_pkg::word_t rs1_data,
    input wire tiny32_pkg::word_t rs2_data,
    input wire tiny32_pkg::word_t io_data_in,
    input wire logic io_ready,
    output tiny32_pkg::instr_u instr,
    output tiny32_pkg::mem_req_t mem_req,
    output logic fetch_en,
    output logic exec_en,
    output logic rf_we,
    output tiny32_pkg::word_t rf_wdata,
    output logic pc_load,
    output logic hlt,
    output logic error,
    output tiny32_pkg::word_t io_address,
    output tiny32_pkg::word_t io_data_out,
    output logic io_req,
    output logic io_nwr
);
    import tiny32_pkg::*;

    typedef enum logic [2:0] {
        st_fetch, st_decode, st_execute, st_memory, st_io_wait, st_writeback
    } state_e;

    state_e state;
    instr_u ir;
    word_t in_data;
    word_t ea;
    logic is_mem, misaligned, out_of_map, fault, pc_fault;

    assign ea = rs1_data + dec.imm;   // load/store effective address
    assign is_mem = dec.opcode == op_load || dec.opcode == op_store;
    assign misaligned = (dec.size == size_half && ea[0]) ||
                        (dec.size == size_word && ea[1:0] != 2'b00);
    assign out_of_map = ea[31:30] != region_rom && ea[31:30] != region_ram;
    assign fault = dec.illegal || (is_mem && (misaligned || out_of_map));
    assign pc_fault = pc[1:0] != 2'b00 || pc[31:30] != region_rom;

    // the fetched word is decoded straight from memory while ir fills
    assign instr = (state == st_decode) ? instr_u'(fetch_data) : ir;

    assign fetch_en = state == st_fetch;
    assign exec_en = state == st_execute;
    assign pc_load = state == st_writeback;
    assign rf_we = state == st_writeback && dec.we;

    always_comb begin
        if (dec.opcode == op_jal || dec.opcode == op_jalr)
            rf_wdata = pc_plus4;
        else if (dec.opcode == op_load)
            rf_wdata = load_data;
        else if (dec.is_in)
            rf_wdata = in_data;
        else
            rf_wdata = alu_result;
    end

    //////////////////////////////////////////////////
    // stage FSM

    always_ff @(posedge clk) begin
        if (!nreset) begin
            state <= st_fetch;
            hlt <= 1'b0;
            error <= 1'b0;
            io_req <= 1'b0;
            io_nwr <= 1'b1;
            mem_req.valid <= 1'b0;
        end else if (!hlt && !error) begin
            case (state)
                st_fetch: begin
                    if (pc_fault)
                        error <= 1'b1;
                    else
                        state <= st_decode;
                end
                st_decode: begin
                    ir <= instr_u'(fetch_data);
                    if (fault) begin
                        error <= 1'b1;
                    end else if (dec.is_hlt) begin
                        hlt <= 1'b1;
                    end else if (dec.is_in || dec.is_out) begin
                        io_req <= 1'b1;
                        io_nwr <= !dec.is_out;
                        io_address <= rs1_data;
                        io_data_out <= rs2_data;
                        state <= st_io_wait;
                    end else if (is_mem) begin
                        mem_req <= '{valid: 1'b1, write: dec.opcode == op_store,
                                     size: dec.size, uns: dec.load_unsigned,
                                     address: ea, wdata: rs2_data};
                        state <= st_memory;
                    end else begin
                        state <= st_execute;
                    end
                end
                st_execute: state <= st_writeback;
                st_memory: begin
                    mem_req.valid <= 1'b0;   // read data lands for writeback
                    state <= st_writeback;
                end
                st_io_wait: begin
                    if (io_ready) begin
                        io_req <= 1'b0;
                        io_nwr <= 1'b1;
                        in_data <= io_data_in;
                        state <= st_writeback;
                    end
                end
                default: state <= st_fetch;   // writeback back to fetch
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/tiny32.sv
`default_nettype none

module tiny32 #(
    parameter int ram_bits = 10,
    parameter int rom_bits = 10
) (
    input wire logic clk,
    input wire logic nreset,
    output logic hlt,
    output logic error,
    output tiny32_pkg::word_t io_address,
    input wire tiny32_pkg::word_t io_data_in,
    output tiny32_pkg::word_t io_data_out,
    output logic io_req,
    output logic io_nwr,
    input wire logic io_ready
);
    import tiny32_pkg::*;

    instr_u instr;
    dec_t dec;
    mem_req_t mem_req;
    word_t fetch_data, load_data;
    word_t alu_result, pc, pc_plus4;
    word_t rs1_data, rs2_data, rf_wdata;
    logic fetch_en, exec_en, rf_we, pc_load, taken;

    tiny32_control control_inst (
        .clk         (clk),
        .nreset      (nreset),
        .dec         (dec),
        .fetch_data  (fetch_data),
        .load_data   (load_data),
        .alu_result  (alu_result),
        .pc          (pc),
        .pc_plus4    (pc_plus4),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .io_data_in  (io_data_in),
        .io_ready    (io_ready),
        .instr       (instr),
        .mem_req     (mem_req),
        .fetch_en    (fetch_en),
        .exec_en     (exec_en),
        .rf_we       (rf_we),
        .rf_wdata    (rf_wdata),
        .pc_load     (pc_load),
        .hlt         (hlt),
        .error       (error),
        .io_address  (io_address),
        .io_data_out (io_data_out),
        .io_req      (io_req),
        .io_nwr      (io_nwr)
    );

    tiny32_decoder decoder_inst (
        .instr (instr),
        .dec   (dec)
    );

    tiny32_alu alu_inst (
        .clk      (clk),
        .dec      (dec),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .exec_en  (exec_en),
        .result   (alu_result),
        .taken    (taken)
    );

    tiny32_regfile regfile_inst (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (dec.rd),
        .wdata  (rf_wdata),
        .raddr1 (dec.rs1),
        .raddr2 (dec.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    tiny32_pc pc_inst (
        .clk      (clk),
        .nreset   (nreset),
        .dec      (dec),
        .rs1_data (rs1_data),
        .taken    (taken),
        .load     (pc_load),
        .pc       (pc),
        .pc_plus4 (pc_plus4)
    );

    tiny32_memory #(
        .ram_bits (ram_bits),
        .rom_bits (rom_bits)
    ) memory_inst (
        .clk        (clk),
        .fetch_en   (fetch_en),
        .fetch_addr (pc),
        .req        (mem_req),
        .fetch_data (fetch_data),
        .load_data  (load_data)
    );

endmodule

`default_nettype wire

// File: testbench/tiny32_tb_tasks.svh
`ifndef tiny32_tb_tasks_svh
`define tiny32_tb_tasks_svh

task automatic fail_run(input string reason);
    $display("TEST RESULT: FAIL");
    $fatal(1, "%s", reason);
endtask

task automatic compare_values(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
        $display("ERROR at %0d ns: %s is %h, expected %h", $time, what, actual, expected);
        fail_run("a DUT output did not match its expected value");
    end
endtask

task automatic apply_reset();
    nreset = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    nreset = 1'b1;
endtask

task automatic reset_outputs_check();
    compare_values({31'b0, hlt}, 32'd0, "hlt after reset");
    compare_values({31'b0, error}, 32'd0, "error after reset");
    compare_values({31'b0, io_req}, 32'd0, "io_req after reset");
    compare_values({31'b0, io_nwr}, 32'd1, "io_nwr after reset");
    compare_values(tiny32_inst.pc, 32'h4000_0000, "pc after reset");
endtask

// holds io_ready low until the test has queued the value
task automatic serve_input(input word_t address, output word_t value);
    while ((address == 32'h10 && a_q.size() == 0) ||
           (address == 32'h14 && b_q.size() == 0) ||
           (address == 32'h18 && cmd_q.size() == 0)) begin
        @(posedge clk);
        #1;
    end
    case (address)
        32'h10: value = a_q.pop_front();
        32'h14: value = b_q.pop_front();
        default: value = cmd_q.pop_front();
    endcase
endtask

task automatic run_iteration(input word_t a, input word_t b, input word_t cmd);
    int target;
    target = cmds_served + 1;
    txn_log.delete();
    a_q.push_back(a);
    b_q.push_back(b);
    cmd_q.push_back(cmd);
    while (cmds_served < target) begin
        @(posedge clk);
        #1;
    end
endtask

function automatic word_t out_data(input word_t address);
    word_t value;
    value = 'x;
    foreach (txn_log[i])
        if (txn_log[i].address == address)
            value = txn_log[i].data;
    return value;
endfunction

// one loop pass reads A and B, makes ten outs and then reads the command
function automatic word_t expected_address(input int index);
    case (index)
        0: return 32'h10;
        1: return 32'h14;
        12: return 32'h18;
        default: return 32'h20 + 4 * (index - 2);
    endcase
endfunction

task automatic wait_for_stop();
    int cycles;
    cycles = 0;
    while (!hlt && !error && cycles < 100) begin
        @(posedge clk);
        #1;
        cycles++;
    end
    if (!hlt && !error)
        fail_run("neither hlt nor error rose after the final command");
endtask

//////////////////////////////////////////////////
// directed tests

task automatic arithmetic_test();
    word_t a;
    word_t b;
    int i;
    for (i = 0; i < 8; i++) begin
        a = $urandom();
        b = $urandom();
        run_iteration(a, b, 32'd0);
        compare_values(out_data(32'h20), a + b, "sum at 0x20");
        compare_values(out_data(32'h24), a - b, "difference at 0x24");
        compare_values(out_data(32'h28), a ^ b, "xor at 0x28");
        compare_values(out_data(32'h2c), a << b[4:0], "left shift at 0x2c");
        compare_values(out_data(32'h30), $signed(a) >>> b[4:0], "arithmetic shift at 0x30");
        compare_values(out_data(32'h34), ($signed(a) < $signed(b)) ? 32'd1 : 32'd0,
                       "signed compare at 0x34");
        compare_values(out_data(32'h38), (a < b) ? 32'd1 : 32'd0, "unsigned compare at 0x38");
    end
endtask

task automatic load_store_test();
    word_t a;
    int i;
    for (i = 0; i < 4; i++) begin
        case (i)
            0: a = 32'h1234_80ff;
            1: a = 32'h8001_7f00;
            2: a = 32'hffff_ffff;
            default: a = $urandom();
        endcase
        run_iteration(a, $urandom(), 32'd0);
        compare_values(out_data(32'h3c), {{24{a[15]}}, a[15:8]}, "signed byte load at 0x3c");
        compare_values(out_data(32'h40), {16'h0000, a[31:16]}, "unsigned half load at 0x40");
    end
endtask

task automatic branch_test();
    word_t a;
    word_t b;
    int i;
    for (i = 0; i < 5; i++) begin
        case (i)
            0: begin
                a = 32'h0000_0005;
                b = 32'h0000_0005;
            end
            1: begin
                a = 32'h8000_0000;
                b = 32'h7fff_ffff;
            end
            2: begin
                a = 32'h7fff_ffff;
                b = 32'h8000_0000;
            end
            3: begin
                a = 32'hffff_ffff;
                b = 32'h0000_0001;
            end
            default: begin
                a = 32'h0000_0003;
                b = 32'h8000_0000;
            end
        endcase
        run_iteration(a, b, 32'd0);
        compare_values(out_data(32'h44), ($signed(a) < $signed(b)) ? 32'd1 : 32'd2,
                       "branch result at 0x44");
    end
endtask

task automatic io_order_test();
    int i;
    run_iteration($urandom(), $urandom(), 32'd0);
    compare_values(txn_log.size(), 32'd13, "io transfers in one loop pass");
    for (i = 0; i < 13; i++) begin
        compare_values(txn_log[i].address, expected_address(i), $sformatf("io %0d address", i));
        compare_values({31'b0, txn_log[i].nwr}, (i < 2 || i == 12) ? 32'd1 : 32'd0,
                       $sformatf("io %0d nwr", i));
    end
endtask

task automatic halt_test();
    int cycles;
    run_iteration($urandom(), $urandom(), 32'd1);
    wait_for_stop();
    compare_values({31'b0, hlt}, 32'd1, "hlt after command 1");
    compare_values({31'b0, error}, 32'd0, "error after command 1");
    for (cycles = 0; cycles < 20; cycles++) begin
        @(posedge clk);
        #1;
        compare_values({31'b0, io_req}, 32'd0, "io_req while halted");
    end
endtask

task automatic error_test();
    apply_reset();
    reset_outputs_check();
    run_iteration(32'h0000_0001, 32'h0000_0002, 32'd2);   // misaligned word load follows
    wait_for_stop();
    compare_values({31'b0, error}, 32'd1, "error after command 2");
    compare_values({31'b0, hlt}, 32'd0, "hlt after command 2");
endtask

`endif

// File: testbench/tiny32_tb.sv
`default_nettype none

module tiny32_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import tiny32_pkg::*;

    localparam int num_iterations = 20;
    localparam int cycles_per_iteration = 2000;
    localparam int watchdog_cycles = num_iterations * cycles_per_iteration + 5000;

    typedef struct packed {
        logic nwr;
        word_t address;
        word_t data;
    } io_txn_t;

    logic clk;
    logic nreset;
    logic hlt;
    logic error;
    word_t io_address;
    word_t io_data_in;
    word_t io_data_out;
    logic io_req;
    logic io_nwr;
    logic io_ready;

    word_t a_q[$];
    word_t b_q[$];
    word_t cmd_q[$];
    io_txn_t txn_log[$];   // every finished io transfer of the current loop pass
    int unsigned io_delays [64];
    int cmds_served;

    tiny32 tiny32_inst (
        .clk         (clk),
        .nreset      (nreset),
        .hlt         (hlt),
        .error       (error),
        .io_address  (io_address),
        .io_data_in  (io_data_in),
        .io_data_out (io_data_out),
        .io_req      (io_req),
        .io_nwr      (io_nwr),
        .io_ready    (io_ready)
    );

    `include "tiny32_tb_tasks.svh"

    always #5 clk = ~clk;

    //////////////////////////////////////////////////
    // io responder

    initial begin
        io_txn_t txn;
        int delay_index;
        io_ready = 1'b0;
        io_data_in = '0;
        delay_index = 0;
        forever begin
            @(posedge clk);
            #1;
            if (io_req === 1'b1) begin
                txn.nwr = io_nwr;
                txn.address = io_address;
                txn.data = io_data_out;
                repeat (io_delays[delay_index % 64]) begin
                    @(posedge clk);
                    #1;
                end
                delay_index++;
                if (txn.address == 32'h10 || txn.address == 32'h14 || txn.address == 32'h18) begin
                    serve_input(txn.address, txn.data);
                    io_data_in = txn.data;
                end
                io_ready = 1'b1;
                @(posedge clk);   // the core samples io_ready here
                #1;
                io_ready = 1'b0;
                txn_log.push_back(txn);
                if (txn.address == 32'h18)
                    cmds_served++;
            end
        end
    end

    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        fail_run("watchdog expired, the test program did not finish in time");
    end

    //////////////////////////////////////////////////
    // test sequence

    initial begin
        int unsigned seed;
        clk = 1'b0;
        nreset = 1'b0;
        cmds_served = 0;
        seed = 32'h92fe_b43b;
        void'($urandom(seed));
        foreach (io_delays[i])
            io_delays[i] = $urandom_range(5, 0);

        apply_reset();
        reset_outputs_check();
        arithmetic_test();
        load_store_test();
        branch_test();
        io_order_test();
        halt_test();
        error_test();

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: program.hex
// one 32-bit instruction word per line, the first word sits at 0x4000_0000
80000337
01000293
0002b50b
01400293
0002b58b
00b50633
02000293
00c2c00b
40b50633
02400293
00c2c00b
00b54633
02800293
00c2c00b
00b51633
02c00293
00c2c00b
40b55633
03000293
00c2c00b
00b52633
03400293
00c2c00b
00b53633
03800293
00c2c00b
00a32023
00130603
03c00293
00c2c00b
00235603
04000293
00c2c00b
00200613
00b54463
0080006f
00100613
020000ef
01800293
0002b38b
f60382e3
00100693
00d39463
0000200b
00232603
04400293
00c2c00b
00008067

// File: flist.f
+incdir+testbench
common/tiny32_pkg.sv
design/tiny32_decoder.sv
design/tiny32_alu.sv
design/tiny32_regfile.sv
design/tiny32_pc.sv
memory/tiny32_memory.sv
control/tiny32_control.sv
design/tiny32.sv
testbench/tiny32_tb.sv

// File: Bender.yml
package:
  name: tiny32

sources:
  - common/tiny32_pkg.sv
  - design/tiny32_decoder.sv
  - design/tiny32_alu.sv
  - design/tiny32_regfile.sv
  - design/tiny32_pc.sv
  - memory/tiny32_memory.sv
  - control/tiny32_control.sv
  - design/tiny32.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tiny32_tb.sv
